// File: Makefile
VERILATOR  ?= verilator
VFLAGS     ?= --binary --timing -Wno-fatal
LINT_FLAGS ?= --lint-only -Wall --timing
TOP        ?= mips_soc_tb
RTL_TOP    ?= mips_soc
FILELIST   ?= filelist.f
OBJ_DIR    ?= obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "Simulation completed successfully"

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR)

// File: dv/mips_soc_tb.sv
`timescale 1ns/100ps
`default_nettype none

module mips_soc_tb;

    localparam int HALT_TIMEOUT = 3000;
    localparam int MODEL_STEPS  = 1000;
    localparam int DATA_BASE    = 40;
    localparam int ALU_RUNS     = 30;
    localparam int MEM_RUNS     = 8;
    localparam int BRANCH_RUNS  = 10;
    localparam int ILLEGAL_RUNS = 6;

    // Every test program normally ends with JR $0.
    localparam mips_isa_pkg::word_t JR_ZERO = {26'd0, mips_isa_pkg::FN_JR};

    logic                  clk;
    logic                  rst_n;
    logic                  load_en;
    avalon_bus_pkg::addr_t load_addr;
    mips_isa_pkg::word_t   load_data;
    logic                  active;
    mips_isa_pkg::word_t   register_v0;

    integer seed;
    int     errors;
    int     timeouts;
    int     checks;
    int     emit_idx;

    // Image of the RAM that the loader writes for the next run.
    mips_isa_pkg::word_t prog_mem [avalon_bus_pkg::MEM_WORDS];

    mips_soc u_mips_soc (
        .clk(clk), .rst_n(rst_n), .load_en(load_en), .load_addr(load_addr),
        .load_data(load_data), .active(active), .register_v0(register_v0)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic check_value(input string what, input mips_isa_pkg::word_t got,
                               input mips_isa_pkg::word_t expected);
        checks++;
        if (got !== expected) begin
            errors++;
            $display("mismatch at %0t: %s, got %h, expected %h", $time, what, got, expected);
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Instruction encoding and random choices.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    function automatic mips_isa_pkg::word_t encode_rtype(input mips_isa_pkg::reg_idx_t rs,
            input mips_isa_pkg::reg_idx_t rt, input mips_isa_pkg::reg_idx_t rd,
            input mips_isa_pkg::funct_t fn);
        return {mips_isa_pkg::OP_RTYPE, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic mips_isa_pkg::word_t encode_itype(input mips_isa_pkg::opcode_t op,
            input mips_isa_pkg::reg_idx_t rs, input mips_isa_pkg::reg_idx_t rt,
            input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic mips_isa_pkg::reg_idx_t pick_reg(input int lo, input int span);
        logic [31:0] r;
        r = $random(seed);
        return mips_isa_pkg::reg_idx_t'(lo + int'(r[15:0]) % span);
    endfunction

    function automatic logic [15:0] pick_imm();
        logic [31:0] r;
        r = $random(seed);
        return r[15:0];
    endfunction

    function automatic mips_isa_pkg::funct_t pick_funct();
        logic [31:0] r;
        r = $random(seed);
        case (int'(r[15:0]) % 6)
            0: return mips_isa_pkg::FN_ADDU;
            1: return mips_isa_pkg::FN_SUBU;
            2: return mips_isa_pkg::FN_AND;
            3: return mips_isa_pkg::FN_OR;
            4: return mips_isa_pkg::FN_XOR;
            default: return mips_isa_pkg::FN_SLT;
        endcase
    endfunction

    function automatic mips_isa_pkg::opcode_t pick_illegal_opcode();
        mips_isa_pkg::opcode_t op;
        logic [31:0] r;
        op = mips_isa_pkg::OP_RTYPE;
        while (op == mips_isa_pkg::OP_RTYPE || op == mips_isa_pkg::OP_ADDIU ||
               op == mips_isa_pkg::OP_LW || op == mips_isa_pkg::OP_SW ||
               op == mips_isa_pkg::OP_BEQ || op == mips_isa_pkg::OP_BNE) begin
            r = $random(seed);
            op = r[5:0];
        end
        return op;
    endfunction

    // Program area is filled with halts, data area with zeros.
    task automatic start_program();
        for (int i = 0; i < avalon_bus_pkg::MEM_WORDS; i++) begin
            prog_mem[i] = (i < DATA_BASE) ? JR_ZERO : '0;
        end
        emit_idx = int'(avalon_bus_pkg::RESET_VECTOR >> 2);
    endtask

    task automatic emit(input mips_isa_pkg::word_t w);
        prog_mem[emit_idx] = w;
        emit_idx++;
    endtask

    task automatic init_regs();
        for (int r = 2; r < 10; r++) begin
            emit(encode_itype(mips_isa_pkg::OP_ADDIU, 5'd0, 5'(r), pick_imm()));
        end
    endtask

    task automatic emit_random_alu();
        logic [31:0] r;
        r = $random(seed);
        if (r[0]) begin
            emit(encode_itype(mips_isa_pkg::OP_ADDIU, pick_reg(2, 8), pick_reg(2, 8),
                              pick_imm()));
        end else begin
            emit(encode_rtype(pick_reg(2, 8), pick_reg(2, 8), pick_reg(2, 8), pick_funct()));
        end
    endtask

    // Folds registers 3 to 9 into v0, then halts.
    task automatic fold_and_halt();
        for (int r = 3; r < 10; r++) begin
            emit(encode_rtype(5'd2, 5'(r), 5'd2, mips_isa_pkg::FN_XOR));
        end
        emit(JR_ZERO);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Instruction-set model.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    function automatic mips_isa_pkg::word_t model_v0();
        mips_isa_pkg::word_t   regs [32];
        mips_isa_pkg::word_t   mem [avalon_bus_pkg::MEM_WORDS];
        mips_isa_pkg::word_t   ins;
        mips_isa_pkg::word_t   a;
        mips_isa_pkg::word_t   b;
        mips_isa_pkg::word_t   imm;
        mips_isa_pkg::word_t   ea;
        avalon_bus_pkg::addr_t pc;
        logic                  halted;
        int                    steps;
        for (int i = 0; i < 32; i++) begin
            regs[i] = '0;
        end
        mem = prog_mem;
        pc = avalon_bus_pkg::RESET_VECTOR;
        halted = 1'b0;
        steps = 0;
        while (!halted && (steps < MODEL_STEPS)) begin
            ins = mem[pc[avalon_bus_pkg::MEM_AW+1:2]];
            a = regs[ins[25:21]];
            b = regs[ins[20:16]];
            imm = {{16{ins[15]}}, ins[15:0]};
            ea = a + imm;
            // No delay slot, so branches count from the next instruction.
            pc = pc + 32'd4;
            case (ins[31:26])
                mips_isa_pkg::OP_RTYPE: begin
                    case (ins[5:0])
                        mips_isa_pkg::FN_ADDU: regs[ins[15:11]] = a + b;
                        mips_isa_pkg::FN_SUBU: regs[ins[15:11]] = a - b;
                        mips_isa_pkg::FN_AND:  regs[ins[15:11]] = a & b;
                        mips_isa_pkg::FN_OR:   regs[ins[15:11]] = a | b;
                        mips_isa_pkg::FN_XOR:  regs[ins[15:11]] = a ^ b;
                        mips_isa_pkg::FN_SLT: begin
                            regs[ins[15:11]] = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        end
                        mips_isa_pkg::FN_JR: begin
                            if (a == '0) begin
                                halted = 1'b1;
                            end else begin
                                pc = a;
                            end
                        end
                        default: halted = 1'b1;
                    endcase
                end
                mips_isa_pkg::OP_ADDIU: regs[ins[20:16]] = ea;
                mips_isa_pkg::OP_LW:    regs[ins[20:16]] = mem[ea[avalon_bus_pkg::MEM_AW+1:2]];
                mips_isa_pkg::OP_SW:    mem[ea[avalon_bus_pkg::MEM_AW+1:2]] = b;
                mips_isa_pkg::OP_BEQ: begin
                    if (a == b) begin
                        pc = pc + {imm[29:0], 2'b00};
                    end
                end
                mips_isa_pkg::OP_BNE: begin
                    if (a != b) begin
                        pc = pc + {imm[29:0], 2'b00};
                    end
                end
                default: halted = 1'b1;
            endcase
            regs[0] = '0;
            steps++;
        end
        return regs[mips_isa_pkg::REG_V0];
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Run control.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic run_program(input string label);
        mips_isa_pkg::word_t expected;
        int cycles;
        expected = model_v0();
        @(negedge clk);
        rst_n = 1'b0;
        // The whole image is loaded while reset is held.
        for (int i = 0; i < avalon_bus_pkg::MEM_WORDS; i++) begin
            load_en   = 1'b1;
            load_addr = avalon_bus_pkg::addr_t'(i * 4);
            load_data = prog_mem[i];
            @(negedge clk);
        end
        load_en = 1'b0;
        check_value({label, ": active in reset"}, {31'd0, active}, 32'd0);
        rst_n = 1'b1;
        @(negedge clk);
        check_value({label, ": active after reset"}, {31'd0, active}, 32'd1);
        cycles = 0;
        while (active && (cycles < HALT_TIMEOUT)) begin
            @(negedge clk);
            cycles++;
        end
        if (active) begin
            timeouts++;
            $display("Timeout at %0t: %s did not halt within %0d cycles",
                     $time, label, HALT_TIMEOUT);
        end else begin
            check_value({label, ": v0"}, register_v0, expected);
        end
    endtask

    initial begin
        seed      = 32'h342c;
        errors    = 0;
        timeouts  = 0;
        checks    = 0;
        emit_idx  = 0;
        rst_n     = 1'b0;
        load_en   = 1'b0;
        load_addr = '0;
        load_data = '0;

        // Reference program stores 0x50, loads it back and doubles it.
        start_program();
        emit(encode_itype(mips_isa_pkg::OP_ADDIU, 5'd0, 5'd3, 16'h0050));
        emit(encode_itype(mips_isa_pkg::OP_SW, 5'd0, 5'd3, 16'd160));
        emit(encode_itype(mips_isa_pkg::OP_LW, 5'd0, 5'd4, 16'd160));
        emit(encode_rtype(5'd3, 5'd4, 5'd2, mips_isa_pkg::FN_ADDU));
        emit(JR_ZERO);
        run_program("reference");
        check_value("reference v0 value", register_v0, 32'h0000_00a0);

        for (int n = 0; n < ALU_RUNS; n++) begin
            start_program();
            init_regs();
            for (int k = 0; k < 16; k++) begin
                emit_random_alu();
            end
            fold_and_halt();
            run_program($sformatf("alu program %0d", n));
        end

        // Stores and loads share a few words so that loads see stored data.
        for (int n = 0; n < MEM_RUNS; n++) begin
            start_program();
            init_regs();
            for (int k = 0; k < 6; k++) begin
                emit(encode_itype(mips_isa_pkg::OP_SW, 5'd0, pick_reg(2, 8),
                                  16'((DATA_BASE + int'(pick_reg(0, 8))) * 4)));
            end
            for (int k = 0; k < 6; k++) begin
                emit(encode_itype(mips_isa_pkg::OP_LW, 5'd0, pick_reg(3, 7),
                                  16'((DATA_BASE + int'(pick_reg(0, 8))) * 4)));
            end
            fold_and_halt();
            run_program($sformatf("memory program %0d", n));
        end

        // Each branch may skip one marked increment of v0.
        for (int n = 0; n < BRANCH_RUNS; n++) begin
            start_program();
            for (int r = 3; r < 7; r++) begin
                emit(encode_itype(mips_isa_pkg::OP_ADDIU, 5'd0, 5'(r),
                                  {15'd0, pick_imm() > 16'h7fff}));
            end
            for (int k = 0; k < 8; k++) begin
                emit(encode_itype((pick_imm() > 16'h7fff) ? mips_isa_pkg::OP_BEQ
                                                          : mips_isa_pkg::OP_BNE,
                                  pick_reg(3, 4), pick_reg(3, 4), 16'd1));
                emit(encode_itype(mips_isa_pkg::OP_ADDIU, 5'd2, 5'd2, 16'(1 << k)));
            end
            emit(JR_ZERO);
            run_program($sformatf("branch program %0d", n));
        end

        for (int n = 0; n < ILLEGAL_RUNS; n++) begin
            start_program();
            init_regs();
            for (int k = 0; k < 4; k++) begin
                emit_random_alu();
            end
            emit({pick_illegal_opcode(), 10'(pick_imm()), pick_imm()});
            emit(encode_itype(mips_isa_pkg::OP_ADDIU, 5'd2, 5'd2, 16'd1));
            fold_and_halt();
            run_program($sformatf("illegal program %0d", n));
        end

        $display("Checks: %0d, errors: %0d, timeouts: %0d", checks, errors, timeouts);
        if ((errors == 0) && (timeouts == 0)) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: filelist.f
hw/mips_isa_pkg.sv
hw/avalon_bus_pkg.sv
hw/register_file.sv
hw/alu.sv
hw/instr_decoder.sv
hw/bus_master.sv
hw/cpu_control.sv
hw/mips_cpu.sv
hw/avalon_ram.sv
hw/mips_soc.sv
dv/mips_soc_tb.sv

// File: hw/alu.sv
`timescale 1ns/100ps
`default_nettype none

module alu (
    input  wire mips_isa_pkg::alu_op_t op,
    input  wire mips_isa_pkg::word_t   a,
    input  wire mips_isa_pkg::word_t   b,
    output mips_isa_pkg::word_t        result,
    output logic                       zero
);

    always_comb begin
        case (op)
            mips_isa_pkg::ALU_ADD: begin
                result = a + b;
            end
            mips_isa_pkg::ALU_SUB: begin
                result = a - b;
            end
            mips_isa_pkg::ALU_AND: begin
                result = a & b;
            end
            mips_isa_pkg::ALU_OR: begin
                result = a | b;
            end
            mips_isa_pkg::ALU_XOR: begin
                result = a ^ b;
            end
            mips_isa_pkg::ALU_SLT: begin
                // Signed compare.
                result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            end
            default: begin
                result = '0;
            end
        endcase
    end

    // Branches subtract the operands and look at this flag.
    assign zero = (result == '0);

endmodule

`default_nettype wire

// File: hw/avalon_bus_pkg.sv
`default_nettype none

package avalon_bus_pkg;

    typedef logic [31:0] addr_t;
    typedef logic [3:0]  byteen_t;

    // RAM geometry, in 32-bit words.
    localparam int unsigned MEM_WORDS = 64;
    localparam int unsigned MEM_AW    = 6;

    // First instruction is fetched from here.
    localparam addr_t RESET_VECTOR = 32'h0000_0004;

    // Wait states inserted by the RAM on every access.
    localparam int unsigned RAM_WAIT_CYCLES = 2;

endpackage

`default_nettype wire

// File: hw/avalon_ram.sv
`timescale 1ns/100ps
`default_nettype none

module avalon_ram (
    input  wire logic                    clk,
    input  wire avalon_bus_pkg::addr_t   address,
    input  wire logic                    read,
    input  wire logic                    write,
    input  wire mips_isa_pkg::word_t     writedata,
    input  wire avalon_bus_pkg::byteen_t byteenable,
    output logic                         waitrequest,
    output mips_isa_pkg::word_t          readdata,
    input  wire logic                    load_en,
    input  wire avalon_bus_pkg::addr_t   load_addr,
    input  wire mips_isa_pkg::word_t     load_data
);

    localparam int unsigned WAIT_W = $clog2(avalon_bus_pkg::RAM_WAIT_CYCLES + 1);

    mips_isa_pkg::word_t mem [avalon_bus_pkg::MEM_WORDS];

    logic [avalon_bus_pkg::MEM_AW-1:0] bus_idx;
    logic [avalon_bus_pkg::MEM_AW-1:0] load_idx;
    logic [WAIT_W-1:0]                 wait_cnt;

    // Word index sits just above the byte offset.
    assign bus_idx  = address[avalon_bus_pkg::MEM_AW+1:2];
    assign load_idx = load_addr[avalon_bus_pkg::MEM_AW+1:2];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Wait states.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // The counter idles at zero whenever no request is up.
    always_ff @(posedge clk) begin
        if (!(read || write) || !waitrequest) begin
            wait_cnt <= '0;
        end else begin
            wait_cnt <= wait_cnt + 1'b1;
        end
    end

    assign waitrequest = (read || write) && (wait_cnt < WAIT_W'(avalon_bus_pkg::RAM_WAIT_CYCLES));

    // Loader has priority; it only runs while the processor is held in reset.
    always_ff @(posedge clk) begin
        if (load_en) begin
            mem[load_idx] <= load_data;
        end else if (write && !waitrequest) begin
            for (int b = 0; b < 4; b++) begin
                if (byteenable[b]) begin
                    mem[bus_idx][8*b +: 8] <= writedata[8*b +: 8];
                end
            end
        end
    end

    assign readdata = mem[bus_idx];

endmodule

`default_nettype wire

// File: hw/bus_master.sv
`timescale 1ns/100ps
`default_nettype none

module bus_master (
    input  wire logic                  clk,
    input  wire logic                  rst_n,
    input  wire logic                  req_read,
    input  wire logic                  req_write,
    input  wire avalon_bus_pkg::addr_t req_addr,
    input  wire mips_isa_pkg::word_t   req_wdata,
    output logic                       req_done,
    output mips_isa_pkg::word_t        rdata,
    output avalon_bus_pkg::addr_t      address,
    output logic                       read,
    output logic                       write,
    output mips_isa_pkg::word_t        writedata,
    output avalon_bus_pkg::byteen_t    byteenable,
    input  wire logic                  waitrequest,
    input  wire mips_isa_pkg::word_t   readdata
);

    // A request starts only from idle, and not in the cycle that reports
    // the previous completion, so a held level is not issued twice.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            read     <= 1'b0;
            write    <= 1'b0;
            req_done <= 1'b0;
        end else begin
            req_done <= 1'b0;
            if (read || write) begin
                if (!waitrequest) begin
                    read     <= 1'b0;
                    write    <= 1'b0;
                    req_done <= 1'b1;
                end
            end else if ((req_read || req_write) && !req_done) begin
                read  <= req_read;
                write <= req_write;
            end
        end
    end

    // Address and data are frozen for the whole transfer.
    always_ff @(posedge clk) begin
        if (!read && !write) begin
            address   <= req_addr;
            writedata <= req_wdata;
        end
        if (read && !waitrequest) begin
            rdata <= readdata;
        end
    end

    // Full words only.
    assign byteenable = '1;

endmodule

`default_nettype wire

// File: hw/cpu_control.sv
`timescale 1ns/100ps
`default_nettype none

module cpu_control (
    input  wire logic                   clk,
    input  wire logic                   rst_n,
    input  wire logic                   is_rtype_alu,
    input  wire logic                   is_addiu,
    input  wire logic                   is_load,
    input  wire logic                   is_store,
    input  wire logic                   is_beq,
    input  wire logic                   is_bne,
    input  wire logic                   is_jr,
    input  wire logic                   illegal,
    input  wire logic                   alu_zero,
    input  wire mips_isa_pkg::word_t    alu_result,
    input  wire mips_isa_pkg::word_t    rs_data,
    input  wire mips_isa_pkg::word_t    imm_ext,
    input  wire mips_isa_pkg::reg_idx_t rt,
    input  wire mips_isa_pkg::reg_idx_t rd,
    input  wire logic                   req_done,
    input  wire mips_isa_pkg::word_t    rdata,
    output mips_isa_pkg::word_t         instr,
    output avalon_bus_pkg::addr_t       pc,
    output logic                        req_read,
    output logic                        req_write,
    output avalon_bus_pkg::addr_t       req_addr,
    output logic                        alu_b_sel_imm,
    output logic                        rf_wr_en,
    output mips_isa_pkg::reg_idx_t      rf_wr_idx,
    output logic                        rf_wr_sel_mem,
    output logic                        active
);

    typedef enum logic [2:0] {
        ST_FETCH,
        ST_DECODE,
        ST_EXECUTE,
        ST_MEMORY,
        ST_WRITEBACK,
        ST_HALT
    } state_t;

    state_t              state;
    mips_isa_pkg::word_t alu_out;
    logic                halt_now;
    logic                take_branch;
    avalon_bus_pkg::addr_t branch_off;

    assign halt_now    = illegal || (is_jr && (rs_data == '0));
    assign take_branch = (is_beq && alu_zero) || (is_bne && !alu_zero);
    assign branch_off  = {imm_ext[29:0], 2'b00};

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Sequencer and program counter.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state  <= ST_FETCH;
            pc     <= avalon_bus_pkg::RESET_VECTOR;
            active <= 1'b0;
        end else begin
            case (state)
                ST_FETCH: begin
                    active <= 1'b1;
                    if (req_done) begin
                        // PC already points past this instruction from here on.
                        pc    <= pc + 32'd4;
                        state <= ST_DECODE;
                    end
                end
                ST_DECODE: begin
                    state <= ST_EXECUTE;
                end
                ST_EXECUTE: begin
                    if (halt_now) begin
                        active <= 1'b0;
                        state  <= ST_HALT;
                    end else begin
                        if (is_jr) begin
                            pc <= rs_data;
                        end else if (take_branch) begin
                            pc <= pc + branch_off;
                        end
                        state <= (is_load || is_store) ? ST_MEMORY : ST_WRITEBACK;
                    end
                end
                ST_MEMORY: begin
                    if (req_done) begin
                        state <= ST_WRITEBACK;
                    end
                end
                ST_WRITEBACK: begin
                    state <= ST_FETCH;
                end
                default: begin
                    state <= ST_HALT;
                end
            endcase
        end
    end

    // Instruction register and ALU result register.
    always_ff @(posedge clk) begin
        if ((state == ST_FETCH) && req_done) begin
            instr <= rdata;
        end
        if (state == ST_EXECUTE) begin
            alu_out <= alu_result;
        end
    end

    // Bus requests are held as levels until the bus phase completes.
    assign req_read  = (state == ST_FETCH) || ((state == ST_MEMORY) && is_load);
    assign req_write = (state == ST_MEMORY) && is_store;
    assign req_addr  = (state == ST_MEMORY) ? alu_out : pc;

    assign alu_b_sel_imm = is_addiu || is_load || is_store;
    assign rf_wr_en      = (state == ST_WRITEBACK) && (is_rtype_alu || is_addiu || is_load);
    assign rf_wr_idx     = is_rtype_alu ? rd : rt;
    assign rf_wr_sel_mem = is_load;

endmodule

`default_nettype wire

// File: hw/instr_decoder.sv
`timescale 1ns/100ps
`default_nettype none

module instr_decoder (
    input  wire mips_isa_pkg::word_t instr,
    output mips_isa_pkg::reg_idx_t   rs,
    output mips_isa_pkg::reg_idx_t   rt,
    output mips_isa_pkg::reg_idx_t   rd,
    output mips_isa_pkg::word_t      imm_ext,
    output mips_isa_pkg::alu_op_t    alu_op,
    output logic                     is_rtype_alu,
    output logic                     is_addiu,
    output logic                     is_load,
    output logic                     is_store,
    output logic                     is_beq,
    output logic                     is_bne,
    output logic                     is_jr,
    output logic                     illegal
);

    mips_isa_pkg::opcode_t opcode;
    mips_isa_pkg::funct_t  funct;

    assign opcode  = instr[31:26];
    assign funct   = instr[5:0];
    assign rs      = instr[25:21];
    assign rt      = instr[20:16];
    assign rd      = instr[15:11];
    assign imm_ext = {{16{instr[15]}}, instr[15:0]};

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Instruction class and ALU operation.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        is_rtype_alu = 1'b0;
        is_addiu     = 1'b0;
        is_load      = 1'b0;
        is_store     = 1'b0;
        is_beq       = 1'b0;
        is_bne       = 1'b0;
        is_jr        = 1'b0;
        illegal      = 1'b0;
        alu_op       = mips_isa_pkg::ALU_ADD;
        case (opcode)
            mips_isa_pkg::OP_RTYPE: begin
                is_rtype_alu = 1'b1;
                case (funct)
                    mips_isa_pkg::FN_ADDU: alu_op = mips_isa_pkg::ALU_ADD;
                    mips_isa_pkg::FN_SUBU: alu_op = mips_isa_pkg::ALU_SUB;
                    mips_isa_pkg::FN_AND:  alu_op = mips_isa_pkg::ALU_AND;
                    mips_isa_pkg::FN_OR:   alu_op = mips_isa_pkg::ALU_OR;
                    mips_isa_pkg::FN_XOR:  alu_op = mips_isa_pkg::ALU_XOR;
                    mips_isa_pkg::FN_SLT:  alu_op = mips_isa_pkg::ALU_SLT;
                    mips_isa_pkg::FN_JR: begin
                        is_rtype_alu = 1'b0;
                        is_jr        = 1'b1;
                    end
                    default: begin
                        is_rtype_alu = 1'b0;
                        illegal      = 1'b1;
                    end
                endcase
            end
            mips_isa_pkg::OP_ADDIU: is_addiu = 1'b1;
            mips_isa_pkg::OP_LW:    is_load  = 1'b1;
            mips_isa_pkg::OP_SW:    is_store = 1'b1;
            mips_isa_pkg::OP_BEQ: begin
                is_beq = 1'b1;
                alu_op = mips_isa_pkg::ALU_SUB;
            end
            mips_isa_pkg::OP_BNE: begin
                is_bne = 1'b1;
                alu_op = mips_isa_pkg::ALU_SUB;
            end
            default: illegal = 1'b1;
        endcase
    end

endmodule

`default_nettype wire

// File: hw/mips_cpu.sv
`timescale 1ns/100ps
`default_nettype none

module mips_cpu (
    input  wire logic                  clk,
    input  wire logic                  rst_n,
    output logic                       active,
    output mips_isa_pkg::word_t        register_v0,
    output avalon_bus_pkg::addr_t      address,
    output logic                       read,
    output logic                       write,
    output mips_isa_pkg::word_t        writedata,
    output avalon_bus_pkg::byteen_t    byteenable,
    input  wire logic                  waitrequest,
    input  wire mips_isa_pkg::word_t   readdata
);

    mips_isa_pkg::word_t    instr;
    mips_isa_pkg::reg_idx_t rs;
    mips_isa_pkg::reg_idx_t rt;
    mips_isa_pkg::reg_idx_t rd;
    mips_isa_pkg::word_t    imm_ext;
    mips_isa_pkg::alu_op_t  alu_op;
    logic is_rtype_alu;
    logic is_addiu;
    logic is_load;
    logic is_store;
    logic is_beq;
    logic is_bne;
    logic is_jr;
    logic illegal;

    mips_isa_pkg::word_t    rs_data;
    mips_isa_pkg::word_t    rt_data;
    mips_isa_pkg::word_t    alu_b;
    mips_isa_pkg::word_t    alu_result;
    logic                   alu_zero;
    logic                   alu_b_sel_imm;
    logic                   rf_wr_en;
    mips_isa_pkg::reg_idx_t rf_wr_idx;
    logic                   rf_wr_sel_mem;
    mips_isa_pkg::word_t    rf_wr_data;

    logic                   req_read;
    logic                   req_write;
    avalon_bus_pkg::addr_t  req_addr;
    logic                   req_done;
    mips_isa_pkg::word_t    rdata;

    // Operand and writeback selection.
    assign alu_b      = alu_b_sel_imm ? imm_ext : rt_data;
    assign rf_wr_data = rf_wr_sel_mem ? rdata : alu_result;

    cpu_control u_cpu_control (
        .clk(clk), .rst_n(rst_n),
        .is_rtype_alu(is_rtype_alu), .is_addiu(is_addiu), .is_load(is_load),
        .is_store(is_store), .is_beq(is_beq), .is_bne(is_bne), .is_jr(is_jr),
        .illegal(illegal), .alu_zero(alu_zero), .alu_result(alu_result),
        .rs_data(rs_data), .imm_ext(imm_ext), .rt(rt), .rd(rd),
        .req_done(req_done), .rdata(rdata), .instr(instr), .pc(),
        .req_read(req_read), .req_write(req_write), .req_addr(req_addr),
        .alu_b_sel_imm(alu_b_sel_imm), .rf_wr_en(rf_wr_en), .rf_wr_idx(rf_wr_idx),
        .rf_wr_sel_mem(rf_wr_sel_mem), .active(active)
    );

    instr_decoder u_instr_decoder (
        .instr(instr), .rs(rs), .rt(rt), .rd(rd), .imm_ext(imm_ext), .alu_op(alu_op),
        .is_rtype_alu(is_rtype_alu), .is_addiu(is_addiu), .is_load(is_load),
        .is_store(is_store), .is_beq(is_beq), .is_bne(is_bne), .is_jr(is_jr),
        .illegal(illegal)
    );

    register_file u_register_file (
        .clk(clk), .rst_n(rst_n), .rs_idx(rs), .rt_idx(rt),
        .rs_data(rs_data), .rt_data(rt_data), .wr_en(rf_wr_en),
        .wr_idx(rf_wr_idx), .wr_data(rf_wr_data), .v0(register_v0)
    );

    alu u_alu (
        .op(alu_op), .a(rs_data), .b(alu_b), .result(alu_result), .zero(alu_zero)
    );

    // Store data comes straight from rt, which is stable through MEMORY.
    bus_master u_bus_master (
        .clk(clk), .rst_n(rst_n), .req_read(req_read), .req_write(req_write),
        .req_addr(req_addr), .req_wdata(rt_data), .req_done(req_done), .rdata(rdata),
        .address(address), .read(read), .write(write), .writedata(writedata),
        .byteenable(byteenable), .waitrequest(waitrequest), .readdata(readdata)
    );

endmodule

`default_nettype wire

// File: hw/mips_isa_pkg.sv
`default_nettype none

package mips_isa_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Word and field types.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [5:0]  opcode_t;
    typedef logic [5:0]  funct_t;

    // Major opcodes of the supported subset.
    localparam opcode_t OP_RTYPE = 6'h00;
    localparam opcode_t OP_BEQ   = 6'h04;
    localparam opcode_t OP_BNE   = 6'h05;
    localparam opcode_t OP_ADDIU = 6'h09;
    localparam opcode_t OP_LW    = 6'h23;
    localparam opcode_t OP_SW    = 6'h2b;

    // R-type function codes.
    localparam funct_t FN_JR   = 6'h08;
    localparam funct_t FN_ADDU = 6'h21;
    localparam funct_t FN_SUBU = 6'h23;
    localparam funct_t FN_AND  = 6'h24;
    localparam funct_t FN_OR   = 6'h25;
    localparam funct_t FN_XOR  = 6'h26;
    localparam funct_t FN_SLT  = 6'h2a;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT
    } alu_op_t;

    // Result register seen by the outside world (v0).
    localparam reg_idx_t REG_V0 = 5'd2;

endpackage

`default_nettype wire

// File: hw/mips_soc.sv
`timescale 1ns/100ps
`default_nettype none

module mips_soc (
    input  wire logic                  clk,
    input  wire logic                  rst_n,
    input  wire logic                  load_en,
    input  wire avalon_bus_pkg::addr_t load_addr,
    input  wire mips_isa_pkg::word_t   load_data,
    output logic                       active,
    output mips_isa_pkg::word_t        register_v0
);

    // Avalon bus between processor and RAM.
    avalon_bus_pkg::addr_t   address;
    logic                    read;
    logic                    write;
    mips_isa_pkg::word_t     writedata;
    avalon_bus_pkg::byteen_t byteenable;
    logic                    waitrequest;
    mips_isa_pkg::word_t     readdata;

    mips_cpu u_mips_cpu (
        .clk(clk), .rst_n(rst_n), .active(active), .register_v0(register_v0),
        .address(address), .read(read), .write(write), .writedata(writedata),
        .byteenable(byteenable), .waitrequest(waitrequest), .readdata(readdata)
    );

    avalon_ram u_avalon_ram (
        .clk(clk), .address(address), .read(read), .write(write),
        .writedata(writedata), .byteenable(byteenable), .waitrequest(waitrequest),
        .readdata(readdata), .load_en(load_en), .load_addr(load_addr),
        .load_data(load_data)
    );

endmodule

`default_nettype wire

// File: hw/register_file.sv
`timescale 1ns/100ps
`default_nettype none

module register_file (
    input  wire logic                  clk,
    input  wire logic                  rst_n,
    input  wire mips_isa_pkg::reg_idx_t rs_idx,
    input  wire mips_isa_pkg::reg_idx_t rt_idx,
    output mips_isa_pkg::word_t        rs_data,
    output mips_isa_pkg::word_t        rt_data,
    input  wire logic                  wr_en,
    input  wire mips_isa_pkg::reg_idx_t wr_idx,
    input  wire mips_isa_pkg::word_t   wr_data,
    output mips_isa_pkg::word_t        v0
);

    mips_isa_pkg::word_t regs [32];

    // Register 0 is cleared by reset and never written after.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && (wr_idx != '0)) begin
            regs[wr_idx] <= wr_data;
        end
    end

    assign rs_data = regs[rs_idx];
    assign rt_data = regs[rt_idx];
    assign v0      = regs[mips_isa_pkg::REG_V0];

endmodule

`default_nettype wire
